//--- hw/rf_pkg.sv
// Register file shared definitions

package rf_pkg;

   ////////////////////////////////////////
   // Array geometry
   ////////////////////////////////////////
   localparam int RF_ADDR_W = 5;
   localparam int RF_DATA_W = 32;
   localparam int RF_DEPTH  = 32;

   ////////////////////////////////////////
   // BIST constants
   ////////////////////////////////////////
   // All-ones in the low bits maps to register 0, so stop one short
   localparam logic [RF_ADDR_W-1:0] TEST_ADDR_LAST = 5'd14;
   // First background, the second one is its complement
   localparam logic [RF_DATA_W-1:0] MARCH_PATTERN  = 32'h5A5A_C3C3;

   // One functional write port
   typedef struct packed {
      logic                 we;
      logic [RF_ADDR_W-1:0] addr;
      logic [RF_DATA_W-1:0] data;
   } rf_wr_port_t;

   // One cycle on the 1RW test interface, strobes are active low
   typedef struct packed {
      logic                 csn;
      logic                 wen;
      logic [RF_ADDR_W-1:0] addr;
      logic [RF_DATA_W-1:0] data;
   } rf_test_req_t;

   // Test address to physical register
   // Top bit dropped, low bits inverted
   function automatic logic [RF_ADDR_W-1:0] test_map_addr(input logic [RF_ADDR_W-1:0] test_addr);
      test_map_addr = {1'b0, ~test_addr[RF_ADDR_W-2:0]};
   endfunction

endpackage

//--- hw/rf_regfile.sv
// Integer register file 3R2W
`timescale 1ns/1ns

module rf_regfile
   import rf_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Read ports, combinational
   input  logic [RF_ADDR_W-1:0] raddr_a_i,
   output logic [RF_DATA_W-1:0] rdata_a_o,
   input  logic [RF_ADDR_W-1:0] raddr_b_i,
   output logic [RF_DATA_W-1:0] rdata_b_o,
   input  logic [RF_ADDR_W-1:0] raddr_c_i,
   output logic [RF_DATA_W-1:0] rdata_c_o,

   // Write ports
   input  rf_wr_port_t          wr_a_i,
   input  rf_wr_port_t          wr_b_i
);

   // Storage for registers 1 and up
   logic [RF_DATA_W-1:0] rf_q  [1:RF_DEPTH-1];
   // Read view with register 0 tied low
   logic [RF_DATA_W-1:0] rf_rd [RF_DEPTH];

   ////////////////////////////////////////
   // Write decode and storage
   ////////////////////////////////////////
   for (genvar i = 1; i < RF_DEPTH; i++)
   begin : g_reg
      logic hit_a;
      logic hit_b;

      // Address match per port
      assign hit_a = wr_a_i.we && (wr_a_i.addr == RF_ADDR_W'(i));
      assign hit_b = wr_b_i.we && (wr_b_i.addr == RF_ADDR_W'(i));

      always_ff @(posedge clk or negedge rst_n)
      begin : reg_write
         if (!rst_n)
         begin
            rf_q[i] <= '0;
         end
         // Port B wins a same-register collision
         else if (hit_b)
         begin
            rf_q[i] <= wr_b_i.data;
         end
         else if (hit_a)
         begin
            rf_q[i] <= wr_a_i.data;
         end
      end
   end

   ////////////////////////////////////////
   // Read side
   ////////////////////////////////////////
   always_comb
   begin
      // Register 0 is not stored
      rf_rd[0] = '0;
      for (int i = 1; i < RF_DEPTH; i++)
      begin
         rf_rd[i] = rf_q[i];
      end
   end

   // Plain muxes, no bypass from the write ports
   assign rdata_a_o = rf_rd[raddr_a_i];
   assign rdata_b_o = rf_rd[raddr_b_i];
   assign rdata_c_o = rf_rd[raddr_c_i];

endmodule

//--- hw/rf_test_wrap.sv
// Register file BIST wrapper
`timescale 1ns/1ns

module rf_test_wrap
   import rf_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Test mode select
   input  logic                 bist_active_i,

   // 1RW test interface
   input  rf_test_req_t         test_req_i,
   output logic [RF_DATA_W-1:0] test_q_o,

   // Functional side
   input  logic [RF_ADDR_W-1:0] raddr_a_i,
   input  rf_wr_port_t          wr_a_i,
   input  rf_wr_port_t          wr_b_i,

   // Towards the register file
   output logic [RF_ADDR_W-1:0] rd_addr_a_o,
   output rf_wr_port_t          wr_a_o,
   output rf_wr_port_t          wr_b_o,
   input  logic [RF_DATA_W-1:0] rdata_a_i
);

   logic                 test_wr;
   logic                 test_rd;
   logic [RF_ADDR_W-1:0] test_addr_map;
   // Mapped address of the last test read
   logic [RF_ADDR_W-1:0] test_raddr_q;

   ////////////////////////////////////////
   // Test strobe decode
   ////////////////////////////////////////
   assign test_wr       = !test_req_i.csn && !test_req_i.wen;
   assign test_rd       = !test_req_i.csn &&  test_req_i.wen;
   assign test_addr_map = test_map_addr(test_req_i.addr);

   ////////////////////////////////////////
   // Write port muxing
   ////////////////////////////////////////
   always_comb
   begin
      if (bist_active_i)
      begin
         // Port A carries the test write, straight through
         wr_a_o.we   = test_wr;
         wr_a_o.addr = test_addr_map;
         wr_a_o.data = test_req_i.data;
         // Port B held off
         wr_b_o      = '0;
      end
      else
      begin
         wr_a_o = wr_a_i;
         wr_b_o = wr_b_i;
      end
   end

   ////////////////////////////////////////
   // Test read address register
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin : test_raddr_reg
      if (!rst_n)
      begin
         test_raddr_q <= '0;
      end
      else if (test_rd)
      begin
         test_raddr_q <= test_addr_map;
      end
   end

   // Read port A follows the registered address in test
   assign rd_addr_a_o = bist_active_i ? test_raddr_q : raddr_a_i;

   // Data valid the cycle after the read request
   assign test_q_o    = rdata_a_i;

endmodule

//--- hw/rf_mbist_ctrl.sv
// March BIST controller
`timescale 1ns/1ns

module rf_mbist_ctrl
   import rf_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Level start, sampled while idle
   input  logic                 start_i,

   // 1RW test interface
   output rf_test_req_t         test_req_o,
   input  logic [RF_DATA_W-1:0] test_q_i,

   // Status
   output logic                 busy_o,
   output logic                 done_o,
   output logic                 fail_o,
   output logic [RF_ADDR_W-1:0] fail_addr_o
);

   ////////////////////////////////////////
   // March sequence
   ////////////////////////////////////////
   // E0 up   w(P)
   // E1 up   r(P) w(~P)
   // E2 down r(~P) w(P)
   // E3 down r(P)
   typedef enum logic [2:0] {
      S_IDLE,
      S_WRITE,
      S_READ,
      S_CMP,
      S_RMW,
      S_DONE
   } state_t;

   state_t               state_q;
   logic [1:0]           elem_q;
   logic [RF_ADDR_W-1:0] addr_q;
   logic                 fail_q;
   logic [RF_ADDR_W-1:0] fail_addr_q;

   logic                 dir_up;
   logic                 addr_last;
   logic [RF_ADDR_W-1:0] addr_step;
   logic [RF_ADDR_W-1:0] addr_first_next;
   logic [RF_DATA_W-1:0] exp_data;
   logic [RF_DATA_W-1:0] wr_data;
   logic                 mismatch;

   // First two elements ascend
   assign dir_up    = (elem_q < 2'd2);
   assign addr_last = dir_up ? (addr_q == TEST_ADDR_LAST) : (addr_q == '0);
   assign addr_step = dir_up ? (addr_q + 1'b1) : (addr_q - 1'b1);
   // Start address of the element after this one
   assign addr_first_next = ((elem_q + 2'd1) < 2'd2) ? '0 : TEST_ADDR_LAST;

   // Backgrounds per element
   assign exp_data = (elem_q == 2'd2) ? ~MARCH_PATTERN : MARCH_PATTERN;
   assign wr_data  = (elem_q == 2'd1) ? ~MARCH_PATTERN : MARCH_PATTERN;
   assign mismatch = (test_q_i != exp_data);

   ////////////////////////////////////////
   // Sequencer
   ////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin : seq
      if (!rst_n)
      begin
         state_q     <= S_IDLE;
         elem_q      <= '0;
         addr_q      <= '0;
         fail_q      <= 1'b0;
         fail_addr_q <= '0;
      end
      else
      begin
         case (state_q)
            S_IDLE:
            begin
               if (start_i)
               begin
                  state_q     <= S_WRITE;
                  elem_q      <= '0;
                  addr_q      <= '0;
                  fail_q      <= 1'b0;
                  fail_addr_q <= '0;
               end
            end
            S_WRITE:
            begin
               // Background fill, then first read element
               if (addr_last)
               begin
                  state_q <= S_READ;
                  elem_q  <= 2'd1;
                  addr_q  <= addr_first_next;
               end
               else
               begin
                  addr_q <= addr_step;
               end
            end
            S_READ:
            begin
               // Wrapper registers the address on this edge
               state_q <= S_CMP;
            end
            S_CMP:
            begin
               // Only the first failure is kept
               if (mismatch && !fail_q)
               begin
                  fail_q      <= 1'b1;
                  fail_addr_q <= addr_q;
               end
               if (elem_q != 2'd3)
               begin
                  state_q <= S_RMW;
               end
               else if (addr_last)
               begin
                  state_q <= S_DONE;
               end
               else
               begin
                  state_q <= S_READ;
                  addr_q  <= addr_step;
               end
            end
            S_RMW:
            begin
               state_q <= S_READ;
               if (addr_last)
               begin
                  elem_q <= elem_q + 2'd1;
                  addr_q <= addr_first_next;
               end
               else
               begin
                  addr_q <= addr_step;
               end
            end
            S_DONE:
            begin
               state_q <= S_IDLE;
            end
            default:
            begin
               state_q <= S_IDLE;
            end
         endcase
      end
   end

   ////////////////////////////////////////
   // Test interface drive
   ////////////////////////////////////////
   always_comb
   begin
      // Deselected by default
      test_req_o.csn  = 1'b1;
      test_req_o.wen  = 1'b1;
      test_req_o.addr = addr_q;
      test_req_o.data = wr_data;
      case (state_q)
         S_WRITE, S_RMW:
         begin
            test_req_o.csn = 1'b0;
            test_req_o.wen = 1'b0;
         end
         S_READ:
         begin
            test_req_o.csn = 1'b0;
         end
         default:
         begin
            test_req_o.csn = 1'b1;
         end
      endcase
   end

   // Status outputs
   assign busy_o      = (state_q != S_IDLE) && (state_q != S_DONE);
   assign done_o      = (state_q == S_DONE);
   assign fail_o      = fail_q;
   assign fail_addr_o = fail_addr_q;

endmodule

//--- hw/rf_subsys_top.sv
// Register file subsystem top
`timescale 1ns/1ns

module rf_subsys_top
   import rf_pkg::*;
(
   input  logic                 clk,
   input  logic                 rst_n,

   // Read ports
   input  logic [RF_ADDR_W-1:0] raddr_a_i,
   input  logic [RF_ADDR_W-1:0] raddr_b_i,
   input  logic [RF_ADDR_W-1:0] raddr_c_i,
   output logic [RF_DATA_W-1:0] rdata_a_o,
   output logic [RF_DATA_W-1:0] rdata_b_o,
   output logic [RF_DATA_W-1:0] rdata_c_o,

   // Write ports
   input  rf_wr_port_t          wr_a_i,
   input  rf_wr_port_t          wr_b_i,

   // BIST control and status
   input  logic                 bist_start_i,
   output logic                 bist_busy_o,
   output logic                 bist_done_o,
   output logic                 bist_fail_o,
   output logic [RF_ADDR_W-1:0] bist_fail_addr_o
);

   rf_test_req_t         test_req;
   logic [RF_DATA_W-1:0] test_q;
   logic [RF_ADDR_W-1:0] mux_rd_addr_a;
   rf_wr_port_t          mux_wr_a;
   rf_wr_port_t          mux_wr_b;

   ////////////////////////////////////////
   // BIST controller
   ////////////////////////////////////////
   rf_mbist_ctrl rf_mbist_ctrl_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .start_i     (bist_start_i),
      .test_req_o  (test_req),
      .test_q_i    (test_q),
      .busy_o      (bist_busy_o),
      .done_o      (bist_done_o),
      .fail_o      (bist_fail_o),
      .fail_addr_o (bist_fail_addr_o)
   );

   // Busy also switches the wrapper into test mode
   rf_test_wrap rf_test_wrap_inst (
      .clk           (clk),
      .rst_n         (rst_n),
      .bist_active_i (bist_busy_o),
      .test_req_i    (test_req),
      .test_q_o      (test_q),
      .raddr_a_i     (raddr_a_i),
      .wr_a_i        (wr_a_i),
      .wr_b_i        (wr_b_i),
      .rd_addr_a_o   (mux_rd_addr_a),
      .wr_a_o        (mux_wr_a),
      .wr_b_o        (mux_wr_b),
      .rdata_a_i     (rdata_a_o)
   );

   // Ports B and C read straight through
   rf_regfile rf_regfile_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .raddr_a_i (mux_rd_addr_a),
      .rdata_a_o (rdata_a_o),
      .raddr_b_i (raddr_b_i),
      .rdata_b_o (rdata_b_o),
      .raddr_c_i (raddr_c_i),
      .rdata_c_o (rdata_c_o),
      .wr_a_i    (mux_wr_a),
      .wr_b_i    (mux_wr_b)
   );

endmodule

//--- sim/rf_subsys_asserts.sv
// BIST masking and status checks
`timescale 1ns/1ns

module rf_subsys_asserts
   import rf_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n,
   input  logic        bist_active_i,
   input  rf_wr_port_t wr_a_i,
   input  rf_wr_port_t wr_b_i,
   input  logic        done_i
);

   ////////////////////////////////////////
   // Test mode write masking
   ////////////////////////////////////////
   // Port B stays quiet while the march runs
   a_wr_b_masked: assert property (
      @(posedge clk) disable iff (!rst_n)
      bist_active_i |-> !wr_b_i.we
   ) else $error("write port B enabled during BIST");

   // Mapped test writes only reach registers 1 to 15
   a_no_test_wr_r0: assert property (
      @(posedge clk) disable iff (!rst_n)
      (bist_active_i && wr_a_i.we) |-> (wr_a_i.addr != '0)
   ) else $error("test write aimed at register 0");

   // Done is a one cycle pulse
   a_done_pulse: assert property (
      @(posedge clk) disable iff (!rst_n)
      done_i |=> !done_i
   ) else $error("BIST done held for more than one cycle");

endmodule

// Done lives in the top, so the checks hang there
bind rf_subsys_top rf_subsys_asserts rf_subsys_asserts_inst (
   .clk           (clk),
   .rst_n         (rst_n),
   .bist_active_i (bist_busy_o),
   .wr_a_i        (mux_wr_a),
   .wr_b_i        (mux_wr_b),
   .done_i        (bist_done_o)
);

//--- sim/tb_rf_subsys.sv
// Register file subsystem testbench
`timescale 1ns/1ns

module tb_rf_subsys
   import rf_pkg::*;
();

   // Busy length of one march run is 15 + 45 + 45 + 30
   localparam int BIST_BUSY_CYCLES = 135;
   // Cycle budget per test for the watchdog
   localparam int RESET_CYCLES = 10;
   localparam int T1_CYCLES    = 2 * RF_DEPTH + 8;
   localparam int T2_CYCLES    = 24 + 2 * RF_DEPTH + 4;
   localparam int T3_CYCLES    = RF_DEPTH / 2 + BIST_BUSY_CYCLES + 8;
   localparam int T4_CYCLES    = RF_DEPTH + 2;
   localparam int T5_CYCLES    = BIST_BUSY_CYCLES + RF_DEPTH + 8;
   localparam int WATCHDOG_CYCLES =
      2 * (RESET_CYCLES + T1_CYCLES + T2_CYCLES + T3_CYCLES + T4_CYCLES + T5_CYCLES) + 100;

   logic                 clk;
   logic                 rst_n;
   logic [RF_ADDR_W-1:0] raddr_a;
   logic [RF_ADDR_W-1:0] raddr_b;
   logic [RF_ADDR_W-1:0] raddr_c;
   logic [RF_DATA_W-1:0] rdata_a;
   logic [RF_DATA_W-1:0] rdata_b;
   logic [RF_DATA_W-1:0] rdata_c;
   rf_wr_port_t          wr_a;
   rf_wr_port_t          wr_b;
   logic                 bist_start;
   logic                 bist_busy;
   logic                 bist_done;
   logic                 bist_fail;
   logic [RF_ADDR_W-1:0] bist_fail_addr;

   // Expected contents of every register
   logic [RF_DATA_W-1:0] model [RF_DEPTH];
   integer               seed = 32'hbedb_6c16;
   int                   errors;
   int                   tests_passed;
   int                   tests_failed;

   rf_subsys_top rf_subsys_top_inst (
      .clk              (clk),
      .rst_n            (rst_n),
      .raddr_a_i        (raddr_a),
      .raddr_b_i        (raddr_b),
      .raddr_c_i        (raddr_c),
      .rdata_a_o        (rdata_a),
      .rdata_b_o        (rdata_b),
      .rdata_c_o        (rdata_c),
      .wr_a_i           (wr_a),
      .wr_b_i           (wr_b),
      .bist_start_i     (bist_start),
      .bist_busy_o      (bist_busy),
      .bist_done_o      (bist_done),
      .bist_fail_o      (bist_fail),
      .bist_fail_addr_o (bist_fail_addr)
   );

   // 4 ns period
   always #2 clk = ~clk;

   ////////////////////////////////////////
   // Reporting helpers
   ////////////////////////////////////////
   task automatic report_mismatch(input string tname, input string what,
                                  input logic [RF_DATA_W-1:0] exp,
                                  input logic [RF_DATA_W-1:0] act);
      errors++;
      $display("FAIL %s: %s expected %h, actual %h", tname, what, exp, act);
   endtask

   task automatic close_test(input string tname, input int errs_before);
      if (errors == errs_before)
      begin
         tests_passed++;
         $display("test %s: ok", tname);
      end
      else
      begin
         tests_failed++;
         $display("test %s: %0d errors", tname, errors - errs_before);
      end
   endtask

   // Physical register reached by a march address
   // Inverting the low four bits gives 15 minus the address
   function automatic logic [RF_ADDR_W-1:0] phys_reg_of(input int test_addr);
      phys_reg_of = RF_ADDR_W'(15 - (test_addr % 16));
   endfunction

   ////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////
   task automatic drive_writes(input logic we_a, input logic [RF_ADDR_W-1:0] addr_a,
                               input logic [RF_DATA_W-1:0] data_a,
                               input logic we_b, input logic [RF_ADDR_W-1:0] addr_b,
                               input logic [RF_DATA_W-1:0] data_b);
      @(posedge clk);
      wr_a.we   <= we_a;
      wr_a.addr <= addr_a;
      wr_a.data <= data_a;
      wr_b.we   <= we_b;
      wr_b.addr <= addr_b;
      wr_b.data <= data_b;
      // Register 0 never stores
      // Port B wins a collision
      if (we_a && addr_a != '0)
         model[addr_a] = data_a;
      if (we_b && addr_b != '0)
         model[addr_b] = data_b;
   endtask

   // Sweep all registers over the three read ports with rotated addresses
   task automatic check_all_regs(input string tname);
      logic [RF_ADDR_W-1:0] a;
      logic [RF_ADDR_W-1:0] b;
      logic [RF_ADDR_W-1:0] c;
      for (int i = 0; i < RF_DEPTH; i++)
      begin
         a = RF_ADDR_W'(i);
         b = ~a;
         c = a + 5'd7;
         @(posedge clk);
         wr_a.we <= 1'b0;
         wr_b.we <= 1'b0;
         raddr_a <= a;
         raddr_b <= b;
         raddr_c <= c;
         @(negedge clk);
         if (rdata_a !== model[a])
            report_mismatch(tname, $sformatf("rdata_a x%0d", a), model[a], rdata_a);
         if (rdata_b !== model[b])
            report_mismatch(tname, $sformatf("rdata_b x%0d", b), model[b], rdata_b);
         if (rdata_c !== model[c])
            report_mismatch(tname, $sformatf("rdata_c x%0d", c), model[c], rdata_c);
      end
   endtask

   // Count busy cycles until the done pulse
   task automatic wait_bist_done(inout int busy_cycles);
      bit done_seen;
      done_seen = 1'b0;
      while (!done_seen)
      begin
         @(negedge clk);
         if (bist_busy)
            busy_cycles++;
         if (bist_done)
            done_seen = 1'b1;
      end
   endtask

   task automatic check_bist_end(input string tname, input int busy_cycles);
      if (busy_cycles != BIST_BUSY_CYCLES)
         report_mismatch(tname, "busy cycles", BIST_BUSY_CYCLES, busy_cycles);
      if (bist_fail !== 1'b0)
         report_mismatch(tname, "bist_fail", 1'b0, bist_fail);
      // A good array never latches a failing address
      if (bist_fail_addr !== '0)
         report_mismatch(tname, "bist_fail_addr", '0, bist_fail_addr);
      @(negedge clk);
      if (bist_busy !== 1'b0 || bist_done !== 1'b0)
      begin
         errors++;
         $display("ERROR %s: busy or done still high after the done pulse", tname);
      end
   endtask

   ////////////////////////////////////////
   // Tests
   ////////////////////////////////////////
   task automatic test_reset_zero();
      int errs;
      errs = errors;
      @(negedge clk);
      if (bist_busy !== 1'b0 || bist_done !== 1'b0 || bist_fail !== 1'b0 ||
          bist_fail_addr !== '0)
      begin
         errors++;
         $display("ERROR reset_zero: BIST status not low after reset");
      end
      check_all_regs("reset_zero");
      // Both ports aim at register 0
      drive_writes(1'b1, '0, $random(seed), 1'b1, '0, $random(seed));
      check_all_regs("reset_zero");
      close_test("reset_zero", errs);
   endtask

   task automatic test_func_rw();
      int                   errs;
      logic [RF_ADDR_W-1:0] addr_a;
      logic [RF_ADDR_W-1:0] addr_b;
      errs = errors;
      for (int k = 0; k < 24; k++)
      begin
         addr_a = RF_ADDR_W'($random(seed));
         addr_b = RF_ADDR_W'($random(seed));
         // Every sixth write collides
         if (k % 6 == 5)
            addr_b = addr_a;
         drive_writes(1'b1, addr_a, $random(seed), 1'b1, addr_b, $random(seed));
         if (k == 11)
            check_all_regs("func_rw");
      end
      check_all_regs("func_rw");
      close_test("func_rw", errs);
   endtask

   task automatic test_bist_good();
      int errs;
      int busy_cycles;
      errs = errors;
      // Preload two registers per cycle
      for (int i = 0; i < RF_DEPTH; i += 2)
      begin
         drive_writes(1'b1, RF_ADDR_W'(i), $random(seed),
                      1'b1, RF_ADDR_W'(i + 1), $random(seed));
      end
      @(posedge clk);
      wr_a.we    <= 1'b0;
      wr_b.we    <= 1'b0;
      bist_start <= 1'b1;
      @(posedge clk);
      bist_start <= 1'b0;
      busy_cycles = 0;
      wait_bist_done(busy_cycles);
      check_bist_end("bist_good", busy_cycles);
      // Last march element leaves the first background everywhere
      for (int t = 0; t <= int'(TEST_ADDR_LAST); t++)
         model[phys_reg_of(t)] = MARCH_PATTERN;
      close_test("bist_good", errs);
   endtask

   task automatic test_pattern_map();
      int errs;
      errs = errors;
      check_all_regs("pattern_map");
      close_test("pattern_map", errs);
   endtask

   task automatic test_masked_writes();
      int errs;
      int busy_cycles;
      errs = errors;
      busy_cycles = 0;
      @(posedge clk);
      bist_start <= 1'b1;
      // Writes to the upper half while the march runs
      for (int i = 0; i < BIST_BUSY_CYCLES - 1; i++)
      begin
         @(posedge clk);
         bist_start <= 1'b0;
         wr_a.we    <= 1'b1;
         wr_a.addr  <= RF_ADDR_W'(16 + ($random(seed) & 15));
         wr_a.data  <= $random(seed);
         wr_b.we    <= 1'b1;
         wr_b.addr  <= RF_ADDR_W'(16 + ($random(seed) & 15));
         wr_b.data  <= $random(seed);
         @(negedge clk);
         if (bist_busy)
            busy_cycles++;
      end
      @(posedge clk);
      wr_a.we <= 1'b0;
      wr_b.we <= 1'b0;
      wait_bist_done(busy_cycles);
      check_bist_end("masked_writes", busy_cycles);
      check_all_regs("masked_writes");
      close_test("masked_writes", errs);
   endtask

   ////////////////////////////////////////
   // Watchdog
   ////////////////////////////////////////
   initial
   begin : watchdog
      repeat (WATCHDOG_CYCLES) @(posedge clk);
      $display("Timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
      $display("Verification failed");
      $finish;
   end

   // Main sequence
   initial
   begin : main
      clk          = 1'b0;
      rst_n        = 1'b0;
      raddr_a      = '0;
      raddr_b      = '0;
      raddr_c      = '0;
      wr_a         = '0;
      wr_b         = '0;
      bist_start   = 1'b0;
      errors       = 0;
      tests_passed = 0;
      tests_failed = 0;
      for (int i = 0; i < RF_DEPTH; i++)
         model[i] = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;

      test_reset_zero();
      test_func_rw();
      test_bist_good();
      test_pattern_map();
      test_masked_writes();

      $display("Tests passed: %0d, failed: %0d, errors: %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0 && tests_failed == 0)
         $display("Verification passed");
      else
         $display("Verification failed");
      $finish;
   end

endmodule

//--- build.f
hw/rf_pkg.sv
hw/rf_regfile.sv
hw/rf_test_wrap.sv
hw/rf_mbist_ctrl.sv
hw/rf_subsys_top.sv
sim/rf_subsys_asserts.sv
sim/tb_rf_subsys.sv

//--- Makefile
# Verilator flow for the register file subsystem

VERILATOR  ?= verilator
TOP        := tb_rf_subsys
RTL_TOP    := rf_subsys_top
FILELIST   := build.f
OBJ_DIR    := obj_dir
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

# Pass only when the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
